// File: filelist.f
src/rv_config_pkg.sv
src/rv_isa_pkg.sv
src/alu.sv
src/regfile.sv
src/immediate_generator.sv
src/singlecycle_datapath.sv
src/singlecycle_control.sv
src/riscv_core.sv
tb/rv_ref_model.sv
tb/tb_riscv_core.sv

// File: Makefile
# Verilator build and run for the RV32I single-cycle core testbench

SOURCES := filelist.f $(wildcard src/*.sv tb/*.sv)

obj_dir/Vtb_riscv_core: $(SOURCES)
	verilator --binary --assert -j 0 --top-module tb_riscv_core -f filelist.f

.PHONY: run clean

# Pass only when the simulation prints the pass message
run: obj_dir/Vtb_riscv_core
	@out="$$(./obj_dir/Vtb_riscv_core)"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '*** PASSED ***'

clean:
	rm -rf obj_dir

// File: tb/tb_riscv_core.sv
// Testbench for the single-cycle RV32I core
// Feeds one random instruction per clock and checks pc and memory traffic
// against the instruction-level model, which also serves as data memory

`timescale 1ns/10ps

module tb_riscv_core
  import rv_config_pkg::*;
  import rv_isa_pkg::*;
();

  localparam int RUN_CYCLES = 2000;
  // x1 to x31 each get a LUI and an ADDI first
  localparam int SEED_CYCLES = 62;
  localparam logic [31:0] LW_ZERO = 32'h0000_2003;
  localparam logic [31:0] SW_ZERO = 32'h0000_2023;

  logic        clock;
  logic        reset;
  logic [31:0] inst;
  logic [31:0] data_mem_read_data;
  logic [31:0] pc;
  logic [31:0] data_mem_address;
  logic [31:0] data_mem_write_data;
  logic        data_mem_read_enable;
  logic        data_mem_write_enable;
  logic [31:0] model_pc;
  logic [31:0] model_address;
  logic [31:0] model_store_data;
  logic        model_load;
  logic        model_store;
  integer      seed;
  int          errors;
  int          checks;
  int          cycle;
  int          i;

  riscv_core riscv_core_i (
    .clock                 (clock),
    .reset                 (reset),
    .inst                  (inst),
    .data_mem_read_data    (data_mem_read_data),
    .pc                    (pc),
    .data_mem_address      (data_mem_address),
    .data_mem_write_data   (data_mem_write_data),
    .data_mem_read_enable  (data_mem_read_enable),
    .data_mem_write_enable (data_mem_write_enable)
  );

  rv_ref_model ref_model (
    .clock        (clock),
    .reset        (reset),
    .inst         (inst),
    .read_address (data_mem_address),
    .read_data    (data_mem_read_data),
    .model_pc     (model_pc),
    .is_load      (model_load),
    .is_store     (model_store),
    .mem_address  (model_address),
    .store_data   (model_store_data)
  );

  initial clock = 1'b0;
  always #10 clock = ~clock;

  // ------------------------------------------------
  // Instruction encoding
  // ------------------------------------------------
  function automatic logic [31:0] encode_r(input logic [6:0] f7, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3,
                                           input logic [4:0] rd, input opcode_t opc);
    return {f7, rs2, rs1, f3, rd, opc};
  endfunction

  function automatic logic [31:0] encode_i(input logic [11:0] imm, input logic [4:0] rs1,
                                           input logic [2:0] f3, input logic [4:0] rd,
                                           input opcode_t opc);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic logic [31:0] encode_s(input logic [11:0] imm, input logic [4:0] rs2,
                                           input logic [4:0] rs1);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], OPC_STORE};
  endfunction

  function automatic logic [31:0] encode_b(input logic [12:0] imm, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OPC_BRANCH};
  endfunction

  function automatic logic [31:0] encode_u(input logic [19:0] imm, input logic [4:0] rd,
                                           input opcode_t opc);
    return {imm, rd, opc};
  endfunction

  function automatic logic [31:0] encode_j(input logic [20:0] imm, input logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OPC_JAL};
  endfunction

  // ------------------------------------------------
  // Random program
  // ------------------------------------------------
  function automatic int unsigned pick(input int unsigned n);
    return $unsigned($random(seed)) % n;
  endfunction

  // x1 to x4 hold the load and store bases and are never overwritten
  function automatic logic [4:0] dest_reg();
    int unsigned n;
    n = pick(28);
    if (n == 0) begin
      return 5'd0;
    end
    return 5'(n + 4);
  endfunction

  function automatic logic [6:0] unknown_opcode(input logic [1:0] sel);
    case (sel)
      2'd0:    return 7'b0001111;
      2'd1:    return 7'b1110011;
      2'd2:    return 7'b0000000;
      default: return 7'b1111111;
    endcase
  endfunction

  function automatic logic [31:0] seed_instruction(input int step);
    logic [4:0]  r;
    logic [31:0] bits;
    r = 5'(step / 2 + 1);
    bits = $random(seed);
    if (r <= 5'd4) begin
      // Bases sit just above 64 KiB, close enough to share words
      if (step % 2 == 0) begin
        return encode_u(20'h00010, r, OPC_LUI);
      end
      return encode_i(12'(r * 96), r, F3_ADD_SUB, r, OPC_OP_IMM);
    end
    if (step % 2 == 0) begin
      return encode_u(bits[31:12], r, OPC_LUI);
    end
    return encode_i(bits[11:0], r, F3_ADD_SUB, r, OPC_OP_IMM);
  endfunction

  function automatic logic [31:0] random_instruction();
    int unsigned kind;
    logic [2:0]  f3;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [11:0] imm12;
    logic [11:0] offset;
    logic [31:0] bits;
    logic        alt;
    kind   = pick(100);
    f3     = 3'(pick(8));
    rd     = dest_reg();
    rs1    = 5'(pick(32));
    rs2    = 5'(pick(32));
    alt    = pick(2) == 1;
    bits   = $random(seed);
    imm12  = bits[11:0];
    offset = {{4{bits[7]}}, bits[7:2], 2'b00};
    if (kind < 35) begin
      if (f3 != F3_ADD_SUB && f3 != F3_SRL_SRA) begin
        alt = 1'b0;
      end
      if (pick(2) == 1) begin
        return encode_r(alt ? FUNCT7_ALT : 7'b0, rs2, rs1, f3, rd, OPC_OP);
      end
      if (f3 == F3_SLL || f3 == F3_SRL_SRA) begin
        imm12 = {alt ? FUNCT7_ALT : 7'b0, bits[24:20]};
      end
      return encode_i(imm12, rs1, f3, rd, OPC_OP_IMM);
    end
    if (kind < 45) begin
      return encode_i(offset, 5'(pick(4) + 1), 3'b010, rd, OPC_LOAD);
    end
    if (kind < 55) begin
      return encode_s(offset, rs2, 5'(pick(4) + 1));
    end
    if (kind < 75) begin
      // 010 and 011 are no branches, fold them onto BEQ and BNE
      if (f3[2:1] == 2'b01) begin
        f3[1] = 1'b0;
      end
      if (pick(4) == 0) begin
        rs2 = rs1;
      end
      return encode_b({bits[12:1], 1'b0}, rs2, rs1, f3);
    end
    if (kind < 85) begin
      if (alt) begin
        return encode_j({bits[20:1], 1'b0}, rd);
      end
      return encode_i(imm12, rs1, 3'b000, rd, OPC_JALR);
    end
    if (kind < 95) begin
      return encode_u(bits[31:12], rd, alt ? OPC_LUI : OPC_AUIPC);
    end
    return {bits[31:7], unknown_opcode(bits[1:0])};
  endfunction

  // ------------------------------------------------
  // Checks
  // ------------------------------------------------
  task automatic compare_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
    checks++;
    assert (got === expected) else begin
      errors++;
      $display("ERR %0t %s got %08h expected %08h", $time, name, got, expected);
    end
  endtask

  task automatic check_cycle();
    compare_value("pc", pc, model_pc);
    compare_value("data_mem_read_enable", {31'b0, data_mem_read_enable}, {31'b0, model_load});
    compare_value("data_mem_write_enable", {31'b0, data_mem_write_enable},
                  {31'b0, model_store});
    if (model_load || model_store) begin
      compare_value("data_mem_address", data_mem_address, model_address);
    end
    if (model_store) begin
      compare_value("data_mem_write_data", data_mem_write_data, model_store_data);
    end
  endtask

  initial begin
    seed   = 32'hb459;
    errors = 0;
    checks = 0;
    reset  = 1'b1;
    inst   = SW_ZERO;

    // Memory strobes stay low while reset holds, even for loads and stores
    for (i = 0; i < 7; i++) begin
      @(posedge clock);
      #1;
      inst = (i % 2 == 0) ? LW_ZERO : SW_ZERO;
      #8;
      compare_value("data_mem_read_enable", {31'b0, data_mem_read_enable}, 32'b0);
      compare_value("data_mem_write_enable", {31'b0, data_mem_write_enable}, 32'b0);
    end

    // Bounded run, one instruction per clock
    for (cycle = 0; cycle < RUN_CYCLES; cycle++) begin
      @(posedge clock);
      #1;
      if (cycle == 0) begin
        reset = 1'b0;
      end
      if (cycle < SEED_CYCLES) begin
        inst = seed_instruction(cycle);
      end else begin
        inst = random_instruction();
      end
      #8;
      if (cycle == 0) begin
        compare_value("pc", pc, INITIAL_PC);
      end
      check_cycle();
    end

    $display("Run of %0d cycles: %0d checks, %0d errors", RUN_CYCLES, checks, errors);
    if (errors == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

// File: tb/rv_ref_model.sv
// Instruction-level model of the RV32I core, stepped once per clock after reset
// Also holds the data memory that answers the DUT's loads

`timescale 1ns/10ps

module rv_ref_model
  import rv_config_pkg::*;
  import rv_isa_pkg::*;
(
  input  logic        clock,
  input  logic        reset,
  input  logic [31:0] inst,
  input  logic [31:0] read_address,
  output logic [31:0] read_data,
  output logic [31:0] model_pc,
  output logic        is_load,
  output logic        is_store,
  output logic [31:0] mem_address,
  output logic [31:0] store_data
);

  // Unwritten words read back as their address scrambled by this key
  localparam logic [31:0] FILL_KEY = 32'h6c1d_a5e3;

  logic [31:0] regs [32];
  logic [31:0] mem [logic [29:0]];
  int unsigned step_count;

  initial begin
    step_count = 0;
    model_pc = INITIAL_PC;
    for (int r = 0; r < 32; r++) begin
      regs[r] = 32'b0;
    end
  end

  function automatic logic [31:0] word_at(input logic [31:0] address);
    if (mem.exists(address[31:2])) begin
      return mem[address[31:2]];
    end
    return {address[31:2], 2'b00} ^ FILL_KEY;
  endfunction

  // ------------------------------------------------
  // Immediate formats
  // ------------------------------------------------
  function automatic logic [31:0] imm_i(input logic [31:0] word);
    return {{20{word[31]}}, word[31:20]};
  endfunction

  function automatic logic [31:0] imm_s(input logic [31:0] word);
    return {{20{word[31]}}, word[31:25], word[11:7]};
  endfunction

  function automatic logic [31:0] imm_b(input logic [31:0] word);
    return {{19{word[31]}}, word[31], word[7], word[30:25], word[11:8], 1'b0};
  endfunction

  function automatic logic [31:0] imm_j(input logic [31:0] word);
    return {{11{word[31]}}, word[31], word[19:12], word[20], word[30:21], 1'b0};
  endfunction

  function automatic logic branch_taken(input logic [2:0] funct3, input logic [31:0] a,
                                        input logic [31:0] b);
    case (funct3)
      F3_BEQ:  return a == b;
      F3_BNE:  return a != b;
      F3_BLT:  return $signed(a) < $signed(b);
      F3_BGE:  return $signed(a) >= $signed(b);
      F3_BLTU: return a < b;
      F3_BGEU: return a >= b;
      default: return 1'b0;
    endcase
  endfunction

  // alt picks SUB and SRA
  function automatic logic [31:0] alu_value(input logic [2:0] funct3, input logic alt,
                                            input logic [31:0] a, input logic [31:0] b);
    case (funct3)
      F3_ADD_SUB: return alt ? a - b : a + b;
      F3_SLL:     return a << b[4:0];
      F3_SLT:     return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      F3_SLTU:    return (a < b) ? 32'd1 : 32'd0;
      F3_XOR:     return a ^ b;
      F3_SRL_SRA: return alt ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
      F3_OR:      return a | b;
      default:    return a & b;
    endcase
  endfunction

  // ------------------------------------------------
  // One instruction per clock
  // ------------------------------------------------
  task automatic execute(input logic [31:0] word);
    logic [31:0] rs1_value;
    logic [31:0] rs2_value;
    logic [31:0] result;
    logic [31:0] address;
    logic [31:0] next_pc;
    logic        writes_rd;
    rs1_value = regs[word[19:15]];
    rs2_value = regs[word[24:20]];
    next_pc   = model_pc + 32'd4;
    result    = 32'b0;
    writes_rd = 1'b1;
    case (word[6:0])
      OPC_LUI:   result = {word[31:12], 12'b0};
      OPC_AUIPC: result = model_pc + {word[31:12], 12'b0};
      OPC_JAL: begin
        result  = model_pc + 32'd4;
        next_pc = model_pc + imm_j(word);
      end
      OPC_JALR: begin
        result  = model_pc + 32'd4;
        next_pc = (rs1_value + imm_i(word)) & ~32'd1;
      end
      OPC_BRANCH: begin
        writes_rd = 1'b0;
        if (branch_taken(word[14:12], rs1_value, rs2_value)) begin
          next_pc = model_pc + imm_b(word);
        end
      end
      OPC_LOAD: result = word_at(rs1_value + imm_i(word));
      OPC_STORE: begin
        writes_rd = 1'b0;
        address = rs1_value + imm_s(word);
        mem[address[31:2]] = rs2_value;
      end
      OPC_OP_IMM: begin
        result = alu_value(word[14:12], word[30] && word[14:12] == F3_SRL_SRA,
                           rs1_value, imm_i(word));
      end
      OPC_OP: result = alu_value(word[14:12], word[30], rs1_value, rs2_value);
      // Anything else leaves the state alone
      default: writes_rd = 1'b0;
    endcase
    if (writes_rd && word[11:7] != 5'd0) begin
      regs[word[11:7]] = result;
    end
    model_pc = next_pc;
  endtask

  always @(posedge clock) begin
    if (reset) begin
      model_pc = INITIAL_PC;
    end else begin
      execute(inst);
    end
    step_count = step_count + 1;
  end

  // Expected memory traffic of the current instruction
  always @(inst or read_address or step_count) begin
    is_load     = (inst[6:0] == OPC_LOAD);
    is_store    = (inst[6:0] == OPC_STORE);
    mem_address = regs[inst[19:15]] + (is_store ? imm_s(inst) : imm_i(inst));
    store_data  = regs[inst[24:20]];
    read_data   = word_at(read_address);
  end

endmodule

// File: src/riscv_core.sv
// RV32I single-cycle core top level
// Instruction and data memories are external with combinational reads

`timescale 1ns/10ps

module riscv_core
  import rv_isa_pkg::*;
(
  input  logic        clock,
  input  logic        reset,
  input  logic [31:0] inst,
  input  logic [31:0] data_mem_read_data,
  output logic [31:0] pc,
  output logic [31:0] data_mem_address,
  output logic [31:0] data_mem_write_data,
  output logic        data_mem_read_enable,
  output logic        data_mem_write_enable
);

  logic            regfile_write_enable;
  wb_select_t      reg_writeback_select;
  next_pc_select_t next_pc_select;
  logic            pc_write_enable;
  alu_function_t   alu_function;
  logic            alu_operand_a_select;
  logic            alu_operand_b_select;
  opcode_t         inst_opcode;
  logic [2:0]      inst_funct3;
  logic [6:0]      inst_funct7;
  logic [31:0]     alu_result;
  logic [31:0]     rs2_data;

  // ------------------------------------------------
  // Memory port mapping
  // ------------------------------------------------
  assign data_mem_address    = alu_result;
  assign data_mem_write_data = rs2_data;

  singlecycle_datapath datapath (
    .clock                (clock),
    .reset                (reset),
    .inst                 (inst),
    .regfile_write_enable (regfile_write_enable),
    .data_mem_read_data   (data_mem_read_data),
    .reg_writeback_select (reg_writeback_select),
    .next_pc_select       (next_pc_select),
    .pc_write_enable      (pc_write_enable),
    .alu_function         (alu_function),
    .alu_operand_a_select (alu_operand_a_select),
    .alu_operand_b_select (alu_operand_b_select),
    .inst_opcode          (inst_opcode),
    .inst_funct3          (inst_funct3),
    .inst_funct7          (inst_funct7),
    .alu_result           (alu_result),
    .rs2_data             (rs2_data),
    .pc                   (pc)
  );

  singlecycle_control control (
    .clock                 (clock),
    .reset                 (reset),
    .inst_opcode           (inst_opcode),
    .inst_funct3           (inst_funct3),
    .inst_funct7           (inst_funct7),
    .alu_result            (alu_result),
    .regfile_write_enable  (regfile_write_enable),
    .reg_writeback_select  (reg_writeback_select),
    .next_pc_select        (next_pc_select),
    .pc_write_enable       (pc_write_enable),
    .alu_function          (alu_function),
    .alu_operand_a_select  (alu_operand_a_select),
    .alu_operand_b_select  (alu_operand_b_select),
    .data_mem_read_enable  (data_mem_read_enable),
    .data_mem_write_enable (data_mem_write_enable)
  );

endmodule

// File: src/singlecycle_control.sv
// Decoder and branch resolution for the single-cycle core
// Turns opcode, funct3 and funct7 into data path strobes each cycle

`timescale 1ns/10ps

module singlecycle_control
  import rv_isa_pkg::*;
(
  input  logic            clock,
  input  logic            reset,
  input  opcode_t         inst_opcode,
  input  logic [2:0]      inst_funct3,
  input  logic [6:0]      inst_funct7,
  input  logic [31:0]     alu_result,
  output logic            regfile_write_enable,
  output wb_select_t      reg_writeback_select,
  output next_pc_select_t next_pc_select,
  output logic            pc_write_enable,
  output alu_function_t   alu_function,
  output logic            alu_operand_a_select,
  output logic            alu_operand_b_select,
  output logic            data_mem_read_enable,
  output logic            data_mem_write_enable
);

  logic funct7_alt;
  logic result_zero;
  logic branch_taken;

  // Shared by OP and OP-IMM, alt only matters for ADD/SUB and SRL/SRA
  function automatic alu_function_t alu_op_decode(input logic [2:0] funct3, input logic alt);
    case (funct3)
      F3_ADD_SUB: return alt ? ALU_SUB : ALU_ADD;
      F3_SLL:     return ALU_SLL;
      F3_SLT:     return ALU_SLT;
      F3_SLTU:    return ALU_SLTU;
      F3_XOR:     return ALU_XOR;
      F3_SRL_SRA: return alt ? ALU_SRA : ALU_SRL;
      F3_OR:      return ALU_OR;
      default:    return ALU_AND;
    endcase
  endfunction

  assign funct7_alt  = |(inst_funct7 & FUNCT7_ALT);
  assign result_zero = (alu_result == 32'b0);

  // ------------------------------------------------
  // Branch compare op and outcome
  // ------------------------------------------------
  always_comb begin
    case (inst_funct3)
      F3_BEQ, F3_BGE, F3_BGEU: branch_taken = result_zero;
      default:                 branch_taken = !result_zero;
    endcase
  end

  assign pc_write_enable = !reset;

  always_comb begin
    regfile_write_enable  = 1'b0;
    reg_writeback_select  = WB_ALU;
    next_pc_select        = NPC_PLUS_4;
    alu_function          = ALU_ADD;
    alu_operand_a_select  = 1'b0;
    alu_operand_b_select  = 1'b0;
    data_mem_read_enable  = 1'b0;
    data_mem_write_enable = 1'b0;
    case (inst_opcode)
      OPC_LUI: begin
        regfile_write_enable = 1'b1;
        reg_writeback_select = WB_IMM;
      end
      OPC_AUIPC: begin
        regfile_write_enable = 1'b1;
        alu_operand_a_select = 1'b1;
        alu_operand_b_select = 1'b1;
      end
      OPC_JAL: begin
        regfile_write_enable = 1'b1;
        reg_writeback_select = WB_PC_PLUS_4;
        next_pc_select       = NPC_BRANCH;
      end
      OPC_JALR: begin
        regfile_write_enable = 1'b1;
        reg_writeback_select = WB_PC_PLUS_4;
        alu_operand_b_select = 1'b1;
        next_pc_select       = NPC_JALR;
      end
      OPC_BRANCH: begin
        case (inst_funct3)
          F3_BLT, F3_BGE:   alu_function = ALU_SLT;
          F3_BLTU, F3_BGEU: alu_function = ALU_SLTU;
          default:          alu_function = ALU_SUB;
        endcase
        if (branch_taken) begin
          next_pc_select = NPC_BRANCH;
        end
      end
      OPC_LOAD: begin
        regfile_write_enable = 1'b1;
        reg_writeback_select = WB_MEM;
        alu_operand_b_select = 1'b1;
        data_mem_read_enable = 1'b1;
      end
      OPC_STORE: begin
        alu_operand_b_select  = 1'b1;
        data_mem_write_enable = 1'b1;
      end
      OPC_OP_IMM: begin
        regfile_write_enable = 1'b1;
        alu_operand_b_select = 1'b1;
        alu_function = alu_op_decode(inst_funct3, funct7_alt && inst_funct3 == F3_SRL_SRA);
      end
      OPC_OP: begin
        regfile_write_enable = 1'b1;
        alu_function         = alu_op_decode(inst_funct3, funct7_alt);
      end
      // Unknown opcodes fall through as a no-op
      default: begin
      end
    endcase
    if (reset) begin
      regfile_write_enable  = 1'b0;
      data_mem_read_enable  = 1'b0;
      data_mem_write_enable = 1'b0;
    end
  end

  a_mem_enables_exclusive: assert property (@(posedge clock)
    !(data_mem_read_enable && data_mem_write_enable));

endmodule

// File: src/singlecycle_datapath.sv
// Single-cycle data path: pc register, operand and writeback muxes
// Wraps the ALU, register file and immediate generator
// Every select comes from singlecycle_control within the same cycle

`timescale 1ns/10ps

module singlecycle_datapath
  import rv_config_pkg::*;
  import rv_isa_pkg::*;
(
  input  logic            clock,
  input  logic            reset,
  input  logic [31:0]     inst,
  input  logic            regfile_write_enable,
  input  logic [31:0]     data_mem_read_data,
  input  wb_select_t      reg_writeback_select,
  input  next_pc_select_t next_pc_select,
  input  logic            pc_write_enable,
  input  alu_function_t   alu_function,
  input  logic            alu_operand_a_select,
  input  logic            alu_operand_b_select,
  output opcode_t         inst_opcode,
  output logic [2:0]      inst_funct3,
  output logic [6:0]      inst_funct7,
  output logic [31:0]     alu_result,
  output logic [31:0]     rs2_data,
  output logic [31:0]     pc
);

  logic [4:0]      inst_rd;
  logic [4:0]      inst_rs1;
  logic [4:0]      inst_rs2;
  logic [XLEN-1:0] immediate;
  logic [XLEN-1:0] rs1_data;
  logic [XLEN-1:0] operand_a;
  logic [XLEN-1:0] operand_b;
  logic [XLEN-1:0] pc_plus_4;
  logic [XLEN-1:0] pc_plus_immediate;
  logic [XLEN-1:0] next_pc;
  logic [XLEN-1:0] writeback_data;

  // ------------------------------------------------
  // Instruction fields
  // ------------------------------------------------
  assign inst_opcode = opcode_t'(inst[6:0]);
  assign inst_rd     = inst[11:7];
  assign inst_funct3 = inst[14:12];
  assign inst_rs1    = inst[19:15];
  assign inst_rs2    = inst[24:20];
  assign inst_funct7 = inst[31:25];

  immediate_generator igen (
    .inst      (inst),
    .immediate (immediate)
  );

  // ------------------------------------------------
  // Register file and ALU
  // ------------------------------------------------
  regfile regs (
    .clock        (clock),
    .rs1_address  (inst_rs1),
    .rs2_address  (inst_rs2),
    .rd_address   (inst_rd),
    .write_enable (regfile_write_enable),
    .rd_data      (writeback_data),
    .rs1_data     (rs1_data),
    .rs2_data     (rs2_data)
  );

  // AUIPC takes pc, immediates replace rs2
  assign operand_a = alu_operand_a_select ? pc : rs1_data;
  assign operand_b = alu_operand_b_select ? immediate : rs2_data;

  alu alu_core (
    .alu_function (alu_function),
    .operand_a    (operand_a),
    .operand_b    (operand_b),
    .result       (alu_result)
  );

  always_comb begin
    case (reg_writeback_select)
      WB_ALU:       writeback_data = alu_result;
      WB_MEM:       writeback_data = data_mem_read_data;
      WB_PC_PLUS_4: writeback_data = pc_plus_4;
      WB_IMM:       writeback_data = immediate;
      default:      writeback_data = '0;
    endcase
  end

  // ------------------------------------------------
  // Next pc
  // ------------------------------------------------
  assign pc_plus_4         = pc + 32'd4;
  assign pc_plus_immediate = pc + immediate;

  always_comb begin
    case (next_pc_select)
      NPC_BRANCH: next_pc = pc_plus_immediate;
      NPC_JALR:   next_pc = {alu_result[XLEN-1:1], 1'b0};
      default:    next_pc = pc_plus_4;
    endcase
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      pc <= INITIAL_PC;
    end else if (pc_write_enable) begin
      pc <= next_pc;
    end
  end

  // First fetch after reset comes from the reset vector
  a_pc_after_reset: assert property (@(posedge clock) $fell(reset) |-> pc == INITIAL_PC);

endmodule

// File: src/immediate_generator.sv
// Immediate extraction for the RV32I formats
// The opcode picks the I, S, B, U or J layout

`timescale 1ns/10ps

module immediate_generator
  import rv_isa_pkg::*;
(
  input  logic [31:0] inst,
  output logic [31:0] immediate
);

  always_comb begin
    case (opcode_t'(inst[6:0]))
      OPC_LOAD, OPC_OP_IMM, OPC_JALR: begin
        immediate = {{21{inst[31]}}, inst[30:20]};
      end
      OPC_STORE: begin
        immediate = {{21{inst[31]}}, inst[30:25], inst[11:7]};
      end
      OPC_BRANCH: begin
        immediate = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
      end
      OPC_LUI, OPC_AUIPC: begin
        immediate = {inst[31:12], 12'b0};
      end
      OPC_JAL: begin
        immediate = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
      end
      // No immediate for OP and unknown opcodes
      default: begin
        immediate = 32'b0;
      end
    endcase
  end

endmodule

// File: src/regfile.sv
// Integer register file, x1 to x31 held in flops
// Two combinational read ports and one write port on the rising edge

`timescale 1ns/10ps

module regfile (
  input  logic        clock,
  input  logic [4:0]  rs1_address,
  input  logic [4:0]  rs2_address,
  input  logic [4:0]  rd_address,
  input  logic        write_enable,
  input  logic [31:0] rd_data,
  output logic [31:0] rs1_data,
  output logic [31:0] rs2_data
);

  // x0 has no storage
  logic [31:0] registers [31:1];

  always_ff @(posedge clock) begin
    if (write_enable && rd_address != 5'd0) begin
      registers[rd_address] <= rd_data;
    end
  end

  assign rs1_data = (rs1_address == 5'd0) ? 32'b0 : registers[rs1_address];
  assign rs2_data = (rs2_address == 5'd0) ? 32'b0 : registers[rs2_address];

endmodule

// File: src/alu.sv
// 32-bit ALU of the single-cycle core
// Fully combinational, driven by the control path's alu_function

`timescale 1ns/10ps

module alu
  import rv_isa_pkg::*;
(
  input  alu_function_t alu_function,
  input  logic [31:0]   operand_a,
  input  logic [31:0]   operand_b,
  output logic [31:0]   result
);

  logic [4:0] shamt;

  // Only the low five bits count for shifts
  assign shamt = operand_b[4:0];

  always_comb begin
    case (alu_function)
      ALU_ADD: begin
        result = operand_a + operand_b;
      end
      ALU_SUB: begin
        result = operand_a - operand_b;
      end
      ALU_SLL: begin
        result = operand_a << shamt;
      end
      ALU_SLT: begin
        result = {31'b0, $signed(operand_a) < $signed(operand_b)};
      end
      ALU_SLTU: begin
        result = {31'b0, operand_a < operand_b};
      end
      ALU_XOR: begin
        result = operand_a ^ operand_b;
      end
      ALU_SRL: begin
        result = operand_a >> shamt;
      end
      ALU_SRA: begin
        result = $unsigned($signed(operand_a) >>> shamt);
      end
      ALU_OR: begin
        result = operand_a | operand_b;
      end
      ALU_AND: begin
        result = operand_a & operand_b;
      end
      default: begin
        result = 32'b0;
      end
    endcase
  end

endmodule

// File: src/rv_isa_pkg.sv
// RV32I encodings shared by the decoder, the data path and the model
// Opcodes, funct fields and the strobe encodings of the control path

package rv_isa_pkg;

  // ------------------------------------------------
  // Major opcodes
  // ------------------------------------------------
  typedef enum logic [6:0] {
    OPC_LUI    = 7'b0110111,
    OPC_AUIPC  = 7'b0010111,
    OPC_JAL    = 7'b1101111,
    OPC_JALR   = 7'b1100111,
    OPC_BRANCH = 7'b1100011,
    OPC_LOAD   = 7'b0000011,
    OPC_STORE  = 7'b0100011,
    OPC_OP_IMM = 7'b0010011,
    OPC_OP     = 7'b0110011
  } opcode_t;

  // ------------------------------------------------
  // Control strobe encodings
  // ------------------------------------------------
  typedef enum logic [4:0] {
    ALU_ADD  = 5'd0,
    ALU_SUB  = 5'd1,
    ALU_SLL  = 5'd2,
    ALU_SLT  = 5'd3,
    ALU_SLTU = 5'd4,
    ALU_XOR  = 5'd5,
    ALU_SRL  = 5'd6,
    ALU_SRA  = 5'd7,
    ALU_OR   = 5'd8,
    ALU_AND  = 5'd9
  } alu_function_t;

  typedef enum logic [2:0] {
    WB_ALU       = 3'd0,
    WB_MEM       = 3'd1,
    WB_PC_PLUS_4 = 3'd2,
    WB_IMM       = 3'd3
  } wb_select_t;

  // NPC_JALR takes the ALU result with bit 0 cleared
  typedef enum logic [1:0] {
    NPC_PLUS_4 = 2'd0,
    NPC_BRANCH = 2'd1,
    NPC_JALR   = 2'd2
  } next_pc_select_t;

  // ------------------------------------------------
  // Funct fields
  // ------------------------------------------------
  localparam logic [2:0] F3_BEQ  = 3'b000;
  localparam logic [2:0] F3_BNE  = 3'b001;
  localparam logic [2:0] F3_BLT  = 3'b100;
  localparam logic [2:0] F3_BGE  = 3'b101;
  localparam logic [2:0] F3_BLTU = 3'b110;
  localparam logic [2:0] F3_BGEU = 3'b111;

  localparam logic [2:0] F3_ADD_SUB = 3'b000;
  localparam logic [2:0] F3_SLL     = 3'b001;
  localparam logic [2:0] F3_SLT     = 3'b010;
  localparam logic [2:0] F3_SLTU    = 3'b011;
  localparam logic [2:0] F3_XOR     = 3'b100;
  localparam logic [2:0] F3_SRL_SRA = 3'b101;
  localparam logic [2:0] F3_OR      = 3'b110;
  localparam logic [2:0] F3_AND     = 3'b111;

  // Selects SUB and SRA/SRAI
  localparam logic [6:0] FUNCT7_ALT = 7'b0100000;

endpackage

// File: src/rv_config_pkg.sv
// Core configuration constants for the RV32I single-cycle core
// Imported by the data path and by the testbench

package rv_config_pkg;

  // ------------------------------------------------
  // Data width and reset state
  // ------------------------------------------------

  // Width of registers, ALU and addresses
  localparam int XLEN = 32;

  // First fetch address after reset
  localparam logic [31:0] INITIAL_PC = 32'h0000_0000;

endpackage
